//--- build.f
+incdir+test
source/wb_bus_pkg.sv
source/board_pkg.sv
source/tick_gen.sv
source/wb_ram.sv
source/wb_display.sv
source/wb_decoder.sv
source/wb_board_top.sv
test/tb_board.sv

//--- run_sim.sh
#!/bin/sh
# compile the board fabric and its testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_board -Mdir obj_dir -o tb_board -f build.f \
   || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_board)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "all tests passed" \
   && echo "simulation PASS" \
   || { echo "simulation FAIL"; exit 1; }

//--- source/board_pkg.sv
//====================================================================
// board package
// seven segment display, button and tick divider constants
//====================================================================
package board_pkg;

   // segment scanner
   localparam int DIGITS = 6;                   // digits on the board
   localparam int SEG_W  = 8;                   // seven segments plus dot

   // lines are active low, all ones means dark
   localparam logic [SEG_W-1:0] SEG_BLANK = 8'hFF;

   // push buttons
   localparam int BTN_W = 4;

   // tick dividers for a 50 MHz bus clock
   localparam int US_DIV_DEF = 50;              // clocks per microsecond
   localparam int MS_DIV_DEF = 1000;            // microseconds per millisecond

endpackage

//--- source/tick_gen.sv
//====================================================================
// tick generator
// divides the bus clock into one cycle microsecond and millisecond
// enable pulses for the display scanner
//====================================================================
module tick_gen
#(
   parameter int US_DIV = board_pkg::US_DIV_DEF,  // clocks per us tick
   parameter int MS_DIV = board_pkg::MS_DIV_DEF   // us ticks per ms tick
)
(
   input  logic   wb_clk,
   input  logic   reset_i,
   output logic   us_tick_o,                    // one cycle every US_DIV clocks
   output logic   ms_tick_o                     // one cycle every MS_DIV us ticks
);

   localparam int US_CW = $clog2(US_DIV + 1);
   localparam int MS_CW = $clog2(MS_DIV + 1);

   logic [US_CW-1:0] us_cnt;                    // clock prescaler
   logic [MS_CW-1:0] ms_cnt;                    // counts us ticks
   logic             us_wrap;
   logic             ms_wrap;

   assign us_wrap = (us_cnt == US_CW'(US_DIV - 1));
   assign ms_wrap = (ms_cnt == MS_CW'(MS_DIV - 1));

   // both pulses are registered at the same edge, so the ms tick
   // always lands on a us tick cycle
   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
      begin
         us_cnt    <= '0;
         ms_cnt    <= '0;
         us_tick_o <= 1'b0;
         ms_tick_o <= 1'b0;
      end
      else
      begin
         us_tick_o <= us_wrap;
         ms_tick_o <= us_wrap & ms_wrap;       // last us of the ms
         us_cnt    <= us_wrap ? '0 : us_cnt + 1'b1;
         if (us_wrap)
            ms_cnt <= ms_wrap ? '0 : ms_cnt + 1'b1;
      end
   end

   // chained counters stay aligned
   a_ms_on_us: assert property (@(posedge wb_clk) disable iff (reset_i)
      ms_tick_o |-> us_tick_o);

endmodule

//--- source/wb_board_top.sv
//====================================================================
// board bus fabric top level
// one external wishbone master, decoder, RAM slave, display slave
// and the tick generator that paces the digit scanner
//====================================================================
module wb_board_top
#(
   parameter int RAM_ADR_BITS = wb_bus_pkg::RAM_ADR_BITS_DEF,
   parameter int US_DIV       = board_pkg::US_DIV_DEF,
   parameter int MS_DIV       = board_pkg::MS_DIV_DEF
)
(
   input  logic                          wb_clk,
   input  logic                          reset_i,
   input  logic [wb_bus_pkg::ADR_W-1:0]  wb_adr_i,   // master address
   input  logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_i,   // master write data
   output logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_o,   // read data to master
   input  logic                          wb_cyc_i,
   input  logic                          wb_we_i,
   input  logic [wb_bus_pkg::SEL_W-1:0]  wb_sel_i,
   input  logic                          wb_stb_i,
   output logic                          wb_ack_o,
   input  logic [board_pkg::BTN_W-1:0]   btn_i,      // push buttons
   output logic [board_pkg::SEG_W-1:0]   seg_o,      // segment mask
   output logic [board_pkg::DIGITS-1:0]  dig_sel_o   // digit select
);

   import wb_bus_pkg::*;

   logic             ram_stb, disp_stb;         // decoded strobes
   logic             ram_ack, disp_ack;         // slave acks
   logic [DAT_W-1:0] ram_dat, disp_dat;         // slave read data
   logic             ms_tick;                   // scanner step

   wb_decoder u_dec
   (
      .wb_adr_i   (wb_adr_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .ram_stb_o  (ram_stb),
      .disp_stb_o (disp_stb),
      .ram_ack_i  (ram_ack),
      .disp_ack_i (disp_ack),
      .ram_dat_i  (ram_dat),
      .disp_dat_i (disp_dat),
      .wb_ack_o   (wb_ack_o),
      .wb_dat_o   (wb_dat_o)
   );

   wb_ram #(.RAM_ADR_BITS(RAM_ADR_BITS)) u_ram
   (
      .wb_clk     (wb_clk),
      .reset_i    (reset_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (ram_dat),
      .wb_cyc_i   (wb_cyc_i),
      .wb_we_i    (wb_we_i),
      .wb_sel_i   (wb_sel_i),
      .wb_stb_i   (ram_stb),
      .wb_ack_o   (ram_ack)
   );

   wb_display u_disp
   (
      .wb_clk     (wb_clk),
      .reset_i    (reset_i),
      .wb_adr_i   (wb_adr_i[2:1]),              // word offset in the block
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (disp_dat),
      .wb_we_i    (wb_we_i),
      .wb_stb_i   (disp_stb),
      .wb_ack_o   (disp_ack),
      .ms_tick_i  (ms_tick),
      .btn_i      (btn_i),
      .seg_o      (seg_o),
      .dig_sel_o  (dig_sel_o)
   );

   tick_gen #(.US_DIV(US_DIV), .MS_DIV(MS_DIV)) u_tick
   (
      .wb_clk     (wb_clk),
      .reset_i    (reset_i),
      .us_tick_o  (),                           // no us consumer on this board
      .ms_tick_o  (ms_tick)
   );

endmodule

//--- source/wb_bus_pkg.sv
//====================================================================
// wishbone bus package
// bus widths and the memory map of the board fabric, shared by the
// decoder, the slaves and the top level
//====================================================================
package wb_bus_pkg;

   // bus geometry
   localparam int ADR_W = 16;                   // byte address
   localparam int DAT_W = 16;                   // data word
   localparam int SEL_W = DAT_W / 8;            // byte lanes

   // RAM slave, 8K words by default
   localparam int RAM_ADR_BITS_DEF = 13;

   // RAM answers whenever the top two address bits are clear
   localparam logic [1:0] RAM_REGION_TAG = 2'b00;

   // display block, eight bytes, matched on bits 15..3
   localparam logic [ADR_W-1:0] DISP_BASE = 16'hFF40;

   // word offsets inside the display block
   localparam logic [1:0] DISP_REG0_OFS = 2'd0;   // digits 0,1
   localparam logic [1:0] DISP_REG1_OFS = 2'd1;   // digits 2,3
   localparam logic [1:0] DISP_BTN_OFS  = 2'd2;   // buttons, read only

endpackage

//--- source/wb_decoder.sv
//====================================================================
// wishbone address decoder
// turns the master address into slave strobes, merges the slave
// acks and muxes the read data back to the master
//====================================================================
module wb_decoder
(
   input  logic [wb_bus_pkg::ADR_W-1:0]  wb_adr_i,   // master byte address
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   output logic                          ram_stb_o,  // RAM region select
   output logic                          disp_stb_o, // display block select
   input  logic                          ram_ack_i,
   input  logic                          disp_ack_i,
   input  logic [wb_bus_pkg::DAT_W-1:0]  ram_dat_i,
   input  logic [wb_bus_pkg::DAT_W-1:0]  disp_dat_i,
   output logic                          wb_ack_o,   // to the master
   output logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_o
);

   import wb_bus_pkg::*;

   logic ram_hit;
   logic disp_hit;
   logic bus_req;

   assign bus_req = wb_cyc_i & wb_stb_i;

   // lower quarter of the map is RAM
   assign ram_hit  = (wb_adr_i[ADR_W-1 -: 2] == RAM_REGION_TAG);
   // eight byte window for the display
   assign disp_hit = (wb_adr_i[ADR_W-1:3] == DISP_BASE[ADR_W-1:3]);

   assign ram_stb_o  = bus_req & ram_hit;
   assign disp_stb_o = bus_req & disp_hit;

   // nothing answers outside the map, the master waits forever
   assign wb_ack_o = ram_ack_i | disp_ack_i;

   // and-or mux, zero when no slave is selected
   assign wb_dat_o = ({DAT_W{ram_stb_o}}  & ram_dat_i)
                   | ({DAT_W{disp_stb_o}} & disp_dat_i);

   // the memory map must keep the regions apart
   always_comb
   begin
      a_one_slave: assert (!(ram_stb_o && disp_stb_o));
   end

endmodule

//--- source/wb_display.sv
//====================================================================
// display slave
// two writable digit registers, a read only button register and a
// six digit multiplexed seven segment scanner
//====================================================================
module wb_display
(
   input  logic                          wb_clk,
   input  logic                          reset_i,
   input  logic [1:0]                    wb_adr_i,   // word offset in the block
   input  logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_i,
   output logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_o,
   input  logic                          wb_we_i,
   input  logic                          wb_stb_i,   // decoded, cyc included
   output logic                          wb_ack_o,
   input  logic                          ms_tick_i,  // digit step enable
   input  logic [board_pkg::BTN_W-1:0]   btn_i,
   output logic [board_pkg::SEG_W-1:0]   seg_o,      // active low segments
   output logic [board_pkg::DIGITS-1:0]  dig_sel_o   // active low digit select
);

   import wb_bus_pkg::*;
   import board_pkg::*;

   localparam int DIG_W = $clog2(DIGITS);

   logic [DAT_W-1:0] disp_reg0;                 // digits 1:0
   logic [DAT_W-1:0] disp_reg1;                 // digits 3:2
   logic [DIG_W-1:0] dig_idx;                   // digit being lit

   // no wait states on this slave
   assign wb_ack_o = wb_stb_i;

   // register writes land at the acknowledging edge
   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
      begin
         disp_reg0 <= '0;
         disp_reg1 <= '0;
      end
      else if (wb_stb_i & wb_we_i)
      begin
         case (wb_adr_i)
            DISP_REG0_OFS: disp_reg0 <= wb_dat_i;
            DISP_REG1_OFS: disp_reg1 <= wb_dat_i;
            default: ;                          // buttons are read only
         endcase
      end
   end

   // read mux, unused offsets read as zero
   always_comb
   begin
      case (wb_adr_i)
         DISP_REG0_OFS: wb_dat_o = disp_reg0;
         DISP_REG1_OFS: wb_dat_o = disp_reg1;
         DISP_BTN_OFS:  wb_dat_o = {{(DAT_W - BTN_W){1'b0}}, btn_i};
         default:       wb_dat_o = '0;
      endcase
   end

   // scan order 0, 5, 4, 3, 2, 1, 0 ...
   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
         dig_idx <= '0;
      else if (ms_tick_i)
      begin
         if (dig_idx == '0)
            dig_idx <= DIG_W'(DIGITS - 1);      // wrap to the top digit
         else
            dig_idx <= dig_idx - 1'b1;
      end
   end

   // segment lines are active low, so bytes go out inverted
   always_comb
   begin
      case (dig_idx)
         DIG_W'(0): seg_o = ~disp_reg0[7:0];
         DIG_W'(1): seg_o = ~disp_reg0[15:8];
         DIG_W'(2): seg_o = ~disp_reg1[7:0];
         DIG_W'(3): seg_o = ~disp_reg1[15:8];
         default:   seg_o = SEG_BLANK;          // digits 4,5 stay dark
      endcase
   end

   // one low bit on the current digit
   assign dig_sel_o = ~(DIGITS'(1) << dig_idx);

   a_dig_range: assert property (@(posedge wb_clk) disable iff (reset_i)
      int'(dig_idx) < DIGITS);

endmodule

//--- source/wb_ram.sv
//====================================================================
// wishbone RAM slave
// word array with byte lane writes, writes acknowledged at once,
// reads acknowledged after two clock edges
//====================================================================
module wb_ram
#(
   parameter int RAM_ADR_BITS = wb_bus_pkg::RAM_ADR_BITS_DEF  // word address bits
)
(
   input  logic                          wb_clk,
   input  logic                          reset_i,
   input  logic [wb_bus_pkg::ADR_W-1:0]  wb_adr_i,   // byte address
   input  logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_i,
   output logic [wb_bus_pkg::DAT_W-1:0]  wb_dat_o,
   input  logic                          wb_cyc_i,
   input  logic                          wb_we_i,
   input  logic [wb_bus_pkg::SEL_W-1:0]  wb_sel_i,   // byte lanes on write
   input  logic                          wb_stb_i,   // already decoded
   output logic                          wb_ack_o
);

   import wb_bus_pkg::*;

   localparam int WORDS = 1 << RAM_ADR_BITS;

   logic [DAT_W-1:0]        mem [0:WORDS-1];    // contents undefined until written
   logic [DAT_W-1:0]        rd_q;               // registered read word
   logic [RAM_ADR_BITS-1:0] word_adr;
   logic                    ram_we;
   logic [1:0]              ack_q;              // read ack pipeline

   // byte address to word index, bit 0 picks the lane only
   assign word_adr = wb_adr_i[RAM_ADR_BITS:1];
   assign ram_we   = wb_we_i & wb_cyc_i & wb_stb_i;

   // lane merge on write, whole word read back every clock
   always_ff @(posedge wb_clk)
   begin
      if (ram_we)
      begin
         for (int i = 0; i < SEL_W; i++)
         begin
            if (wb_sel_i[i])
               mem[word_adr][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
         end
      end
      rd_q <= mem[word_adr];
   end

   assign wb_dat_o = rd_q;

   // stage 0 sees the strobe at edge 1, stage 1 at edge 2
   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
         ack_q <= 2'b00;
      else
      begin
         ack_q[0] <= wb_cyc_i & wb_stb_i;
         ack_q[1] <= wb_cyc_i & ack_q[0];
      end
   end

   // write acks in its first cycle, read waits on the pipeline
   assign wb_ack_o = wb_cyc_i & wb_stb_i & (ack_q[1] | wb_we_i);

   // a read ack needs the strobe held at both pipeline edges
   a_rd_ack_held: assert property (@(posedge wb_clk) disable iff (reset_i)
      (wb_ack_o && !wb_we_i) |-> ($past(wb_cyc_i && wb_stb_i)
                                  && $past(wb_cyc_i && wb_stb_i, 2)));

endmodule

//--- test/tb_board_ref.svh
//====================================================================
// board reference model
// shadow RAM with byte lane merge, copies of the display registers
// and the expected segment mask and scan order per digit
//====================================================================
`ifndef TB_BOARD_REF_SVH
`define TB_BOARD_REF_SVH

logic [DAT_W-1:0] shadow_mem [int];             // word index to last value
logic [DAT_W-1:0] ref_reg0;                     // digits 0 and 1
logic [DAT_W-1:0] ref_reg1;                     // digits 2 and 3

// RAM region is the lower quarter, bit 0 only picks a lane
function automatic int ram_word(input logic [ADR_W-1:0] adr);
   return int'(adr[ADR_W-3:1]);
endfunction

task automatic shadow_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat,
                            input logic [SEL_W-1:0] sel);
   logic [DAT_W-1:0] word;
   word = shadow_mem.exists(ram_word(adr)) ? shadow_mem[ram_word(adr)] : 'x;
   for (int i = 0; i < SEL_W; i++)
   begin
      if (sel[i])
         word[i*8 +: 8] = dat[i*8 +: 8];        // only enabled lanes change
   end
   shadow_mem[ram_word(adr)] = word;
endtask

function automatic logic [DAT_W-1:0] shadow_read(input logic [ADR_W-1:0] adr);
   return shadow_mem[ram_word(adr)];
endfunction

task automatic disp_ref_reset();
   ref_reg0 = '0;
   ref_reg1 = '0;
endtask

task automatic disp_ref_write(input logic [1:0] ofs, input logic [DAT_W-1:0] dat);
   if (ofs == DISP_REG0_OFS)
      ref_reg0 = dat;
   else if (ofs == DISP_REG1_OFS)
      ref_reg1 = dat;                           // buttons ignore writes
endtask

function automatic logic [DAT_W-1:0] disp_ref_read(input logic [1:0] ofs,
                                                   input logic [BTN_W-1:0] btn);
   case (ofs)
      DISP_REG0_OFS: return ref_reg0;
      DISP_REG1_OFS: return ref_reg1;
      DISP_BTN_OFS:  return DAT_W'(btn);        // zero extended
      default:       return '0;
   endcase
endfunction

// active low lines, so the byte goes out inverted
function automatic logic [SEG_W-1:0] expected_seg(input int idx);
   case (idx)
      0:       return ~ref_reg0[7:0];
      1:       return ~ref_reg0[15:8];
      2:       return ~ref_reg1[7:0];
      3:       return ~ref_reg1[15:8];
      default: return SEG_BLANK;                // digits 4 and 5 dark
   endcase
endfunction

// 0 wraps to the top digit, others count down
function automatic int next_digit(input int idx);
   return (idx == 0) ? DIGITS - 1 : idx - 1;
endfunction

`endif

//--- test/tb_board.sv
//====================================================================
// board fabric testbench
// drives the wishbone master port and checks RAM, display registers,
// digit scanning, unmapped access and reset against a reference model
//====================================================================
module tb_board;

   import wb_bus_pkg::*;
   import board_pkg::*;

   localparam int ACK_TIMEOUT = 20;             // cycles per bus access
   localparam int SCAN_TICKS  = 50;             // digit steps watched
   localparam int SCAN_LIMIT  = 600;            // cycles allowed for them

   logic              wb_clk;
   logic              reset_i;
   logic [ADR_W-1:0]  wb_adr_i;
   logic [DAT_W-1:0]  wb_dat_i;
   logic [DAT_W-1:0]  wb_dat_o;
   logic              wb_cyc_i;
   logic              wb_we_i;
   logic [SEL_W-1:0]  wb_sel_i;
   logic              wb_stb_i;
   logic              wb_ack_o;
   logic [BTN_W-1:0]  btn_i;
   logic [SEG_W-1:0]  seg_o;
   logic [DIGITS-1:0] dig_sel_o;

   integer          seed = 32'h249f879b;
   int              errors = 0;
   int              checks = 0;
   int              tests_run = 0;
   int              tests_bad = 0;
   int              test_errs0 = 0;             // errors before this test
   bit              scan_en = 1'b0;
   int              scan_prev;
   int              scan_steps;
   bit [DIGITS-1:0] digit_seen;

   `include "tb_board_ref.svh"

   wb_board_top #(.RAM_ADR_BITS(RAM_ADR_BITS_DEF), .US_DIV(2), .MS_DIV(3)) dut
   (
      .wb_clk (wb_clk), .reset_i (reset_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o), .wb_cyc_i (wb_cyc_i), .wb_we_i (wb_we_i), .wb_sel_i (wb_sel_i),
      .wb_stb_i (wb_stb_i), .wb_ack_o (wb_ack_o), .btn_i (btn_i), .seg_o (seg_o),
      .dig_sel_o (dig_sel_o)
   );

   always #50 wb_clk = ~wb_clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic note_error(input string msg);
      errors++;
      $display("error: %s at %0t", msg, $time);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_errs0)
         $display("test %0d %s: ok", tests_run, name);
      else
      begin
         tests_bad++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - test_errs0);
      end
      test_errs0 = errors;
   endtask

   task automatic next_drive();
      @(posedge wb_clk);
      #5;                                       // inputs move just after the edge
   endtask

   // one classic cycle, called at the drive point after an edge
   task automatic bus_xfer(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [DAT_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                           output logic [DAT_W-1:0] rdat, output int edges, output bit acked);
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_sel_i = sel;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      acked    = 1'b0;
      edges    = 0;                             // rising edges before ack
      rdat     = '0;
      while (!acked && edges < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);                     // mid cycle, ack and data settled
         if (wb_ack_o)
         begin
            acked = 1'b1;
            rdat  = wb_dat_o;
         end
         else
            edges++;
      end
      next_drive();                             // drop at the ack edge
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      next_drive();                             // one idle cycle
   endtask

   task automatic check_ack(input bit acked, input int edges, input int exp_edges,
                            input string what);
      if (!acked)
         note_error({"no ack on ", what, " within the timeout"});
      else
         check_value({what, " ack edges"}, edges, exp_edges);
   endtask

   function automatic int low_bit_index(input logic [DIGITS-1:0] sel);
      int idx;
      idx = -1;
      for (int i = 0; i < DIGITS; i++)
      begin
         if (!sel[i])
            idx = i;
      end
      return idx;
   endfunction

   // segment and order compare while the scan window is open
   always @(negedge wb_clk)
   begin : scan_check
      int cur;
      if (scan_en && $countones(~dig_sel_o) == 1)
      begin
         cur = low_bit_index(dig_sel_o);
         check_value("seg_o", seg_o, expected_seg(cur));
         digit_seen[cur] = 1'b1;
         if (scan_prev >= 0 && cur != scan_prev)
         begin
            check_value("digit order", cur, next_digit(scan_prev));
            scan_steps++;
         end
         scan_prev = cur;
      end
   end

   initial
   begin
      logic [ADR_W-1:0] adr_q [$];              // addresses of test 1
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
      logic [DAT_W-1:0] rdat;
      int               edges;
      int               cycles;
      bit               acked;
      wb_clk   = 1'b0;
      reset_i  = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_sel_i = '0;
      wb_stb_i = 1'b0;
      btn_i    = '0;
      disp_ref_reset();
      repeat (16) @(posedge wb_clk);
      #5;
      reset_i = 1'b0;

      // random words in the RAM region, word aligned
      for (int i = 0; i < 16; i++)
      begin
         adr = ADR_W'($random(seed)) & 16'h3FFE;
         dat = DAT_W'($random(seed));
         bus_xfer(1'b1, adr, dat, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 0, "ram write");
         shadow_write(adr, dat, 2'b11);
         adr_q.push_back(adr);
      end
      foreach (adr_q[i])
      begin
         bus_xfer(1'b0, adr_q[i], '0, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 2, "ram read");
         check_value("wb_dat_o", rdat, shadow_read(adr_q[i]));
      end
      end_test("ram word write and read");

      // lanes 01, 10, 11 over a known word
      for (int i = 0; i < 3; i++)
      begin
         adr = 16'h0200 + ADR_W'(2 * i);
         bus_xfer(1'b1, adr, 16'hA5C3, 2'b11, rdat, edges, acked);
         shadow_write(adr, 16'hA5C3, 2'b11);
         bus_xfer(1'b1, adr, 16'h1E2D, SEL_W'(i + 1), rdat, edges, acked);
         check_ack(acked, edges, 0, "lane write");
         shadow_write(adr, 16'h1E2D, SEL_W'(i + 1));
         bus_xfer(1'b0, adr, '0, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 2, "ram read");
         check_value("wb_dat_o", rdat, shadow_read(adr));
      end
      end_test("byte lanes");

      btn_i = 4'hA;
      for (int ofs = 0; ofs < 2; ofs++)
      begin
         dat = DAT_W'($random(seed));
         bus_xfer(1'b1, DISP_BASE + ADR_W'(2 * ofs), dat, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 0, "display write");
         disp_ref_write(2'(ofs), dat);
      end
      for (int ofs = 0; ofs < 4; ofs++)
      begin
         bus_xfer(1'b0, DISP_BASE + ADR_W'(2 * ofs), '0, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 0, "display read");
         check_value("wb_dat_o", rdat, disp_ref_read(2'(ofs), btn_i));
      end
      end_test("display registers");

      scan_prev  = -1;
      scan_steps = 0;
      digit_seen = '0;
      scan_en    = 1'b1;
      cycles     = 0;
      while (scan_steps < SCAN_TICKS && cycles < SCAN_LIMIT)
      begin
         @(posedge wb_clk);
         cycles++;
      end
      #5;
      scan_en = 1'b0;
      if (scan_steps < SCAN_TICKS)
         note_error($sformatf("scanner made only %0d digit steps in %0d cycles",
                              scan_steps, cycles));
      for (int d = 0; d < DIGITS; d++)
      begin
         if (!digit_seen[d])
            note_error($sformatf("digit %0d was never selected", d));
      end
      end_test("digit scanning");

      bus_xfer(1'b0, 16'h8000, '0, 2'b11, rdat, edges, acked);
      if (acked)
         note_error("unmapped read at 0x8000 was acknowledged");
      else
         $display("unmapped read at 0x8000 got no ack in %0d cycles, as expected", edges);
      bus_xfer(1'b0, adr_q[0], '0, 2'b11, rdat, edges, acked);
      check_ack(acked, edges, 2, "ram read");
      check_value("wb_dat_o", rdat, shadow_read(adr_q[0]));
      end_test("unmapped address");

      reset_i = 1'b1;
      repeat (4) next_drive();
      reset_i = 1'b0;
      disp_ref_reset();
      @(negedge wb_clk);
      check_value("wb_ack_o", wb_ack_o, 1'b0);  // stb is low here
      next_drive();
      for (int ofs = 0; ofs < 2; ofs++)
      begin
         bus_xfer(1'b0, DISP_BASE + ADR_W'(2 * ofs), '0, 2'b11, rdat, edges, acked);
         check_ack(acked, edges, 0, "display read");
         check_value("wb_dat_o", rdat, disp_ref_read(2'(ofs), btn_i));
      end
      end_test("second reset");

      $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
